/* hdl/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Datapath sizing for the decode stage
`define ID_DATA_W   32      // Word width
`define ID_NUM_REGS 32      // Register file depth
`define ID_REG_W    5       // Register index width

// Stack pointer lives in r29
`define ID_SP_REG   5'd29

`endif

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// Opcode field encodings
	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_NAND = 6'd4,
		OP_XOR  = 6'd5,
		OP_ADDI = 6'd6,
		OP_ANDI = 6'd7,
		OP_LW   = 6'd8,
		OP_SW   = 6'd9,
		OP_BEQ  = 6'd10,
		OP_JMP  = 6'd11,
		OP_LI   = 6'd12,
		OP_SLL  = 6'd13,
		OP_SRL  = 6'd14,
		OP_PUSH = 6'd15,	// Stack ops use r29
		OP_POP  = 6'd16,
		OP_CALL = 6'd17,
		OP_RET  = 6'd18,
		OP_SLD  = 6'd19		// Sprite load
	} opcode_t;

	// Instruction field bit positions
	localparam int unsigned OPC_HI   = 31, OPC_LO   = 26;
	localparam int unsigned RD_HI    = 25, RD_LO    = 21;
	localparam int unsigned RS_HI    = 20, RS_LO    = 16;
	localparam int unsigned RT_HI    = 15, RT_LO    = 11;
	localparam int unsigned SHAMT_HI = 10, SHAMT_LO = 6;
	localparam int unsigned IMM16_HI = 15, IMM16_LO = 0;	// Overlaps rt and shamt
	localparam int unsigned IMM26_HI = 25, IMM26_LO = 0;	// J-type target

endpackage

`default_nettype wire

/* hdl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	// ALU operand source select
	typedef enum logic [1:0] {
		SRC_REG_REG   = 2'b00,	// Both read buses
		SRC_REG_IMM   = 2'b01,	// Bus 1 or PC with sign-extended imm
		SRC_REG_SHIFT = 2'b10,	// Bus 1 with shamt or one
		SRC_SPRITE    = 2'b11	// Both operands zero
	} alu_src_t;

endpackage

`default_nettype wire

/* hdl/decode_control.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_control (
	input  isa_pkg::opcode_t   opcode,
	output logic               call,
	output logic               ret,
	output logic               branch,
	output logic               push_pop,	// PUSH or POP
	output logic               pop,
	output logic               reg_2_sel,	// High picks rt for port 2
	output logic               sign_ext_sel,	// High picks 26-bit imm
	output ctrl_pkg::alu_src_t alu_src
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	always_comb begin
		// Defaults match NOP
		call         = 1'b0;
		ret          = 1'b0;
		branch       = 1'b0;
		push_pop     = 1'b0;
		pop          = 1'b0;
		reg_2_sel    = 1'b0;
		sign_ext_sel = 1'b0;
		alu_src      = SRC_REG_REG;

		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_NAND, OP_XOR: begin
				reg_2_sel = 1'b1;		// rs op rt
				alu_src   = SRC_REG_REG;
			end
			OP_ADDI, OP_ANDI, OP_LW, OP_SW, OP_LI: begin
				alu_src = SRC_REG_IMM;	// SW store data comes from rd on port 2
			end
			OP_BEQ: begin
				alu_src = SRC_REG_IMM;
				branch  = 1'b1;		// PC plus offset
			end
			OP_JMP: begin
				alu_src      = SRC_REG_IMM;
				branch       = 1'b1;
				sign_ext_sel = 1'b1;	// Long target
			end
			OP_SLL, OP_SRL: alu_src = SRC_REG_SHIFT;
			OP_PUSH: begin
				alu_src  = SRC_REG_SHIFT;
				push_pop = 1'b1;
			end
			OP_POP: begin
				alu_src  = SRC_REG_SHIFT;
				push_pop = 1'b1;
				pop      = 1'b1;		// Forces a write-back
			end
			OP_CALL: begin
				alu_src = SRC_REG_SHIFT;
				call    = 1'b1;
			end
			OP_RET: begin
				alu_src = SRC_REG_SHIFT;
				ret     = 1'b1;
			end
			OP_SLD:  alu_src = SRC_SPRITE;
			default: alu_src = SRC_REG_REG;	// NOP and unused codes
		endcase
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  logic [`ID_REG_W-1:0]  rd_idx_1,
	input  logic [`ID_REG_W-1:0]  rd_idx_2,
	input  logic [`ID_REG_W-1:0]  wr_idx,
	input  logic [`ID_DATA_W-1:0] wr_data,
	output logic [`ID_DATA_W-1:0] rd_data_1,
	output logic [`ID_DATA_W-1:0] rd_data_2
);

	logic [`ID_DATA_W-1:0] mem [`ID_NUM_REGS];

	// Single write port
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ID_NUM_REGS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// No bypass, same-edge write shows up next cycle
	assign rd_data_1 = mem[rd_idx_1];
	assign rd_data_2 = mem[rd_idx_2];

endmodule

`default_nettype wire

/* hdl/id_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module id_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  call,
	input  logic                  ret,
	input  logic                  branch,
	input  logic                  push_pop,
	input  logic                  pop,
	input  logic                  reg_2_sel,
	input  logic                  sign_ext_sel,
	input  ctrl_pkg::alu_src_t    alu_src,
	input  logic                  wb_we,		// Write-back side
	input  logic [`ID_REG_W-1:0]  wb_reg,
	input  logic [`ID_DATA_W-1:0] wb_data,
	input  logic [`ID_REG_W-1:0]  rd,		// Instruction fields
	input  logic [`ID_REG_W-1:0]  rs,
	input  logic [`ID_REG_W-1:0]  rt,
	input  logic [4:0]            shamt,
	input  logic [15:0]           imm16,
	input  logic [25:0]           imm26,
	input  logic [`ID_DATA_W-1:0] pc_in,		// PC+1 from fetch
	output logic [`ID_REG_W-1:0]  dest,
	output logic [15:0]           imm16_out,	// Raw imm for LI
	output logic [`ID_DATA_W-1:0] alu_in_1,
	output logic [`ID_DATA_W-1:0] alu_in_2,
	output logic [`ID_DATA_W-1:0] pc_out
);

	import ctrl_pkg::*;

	logic                  sp_sel;		// Stack op reads r29
	logic                  rf_we;
	logic [`ID_REG_W-1:0]  rd_idx_1;
	logic [`ID_REG_W-1:0]  rd_idx_2;
	logic [`ID_DATA_W-1:0] rd_bus_1;
	logic [`ID_DATA_W-1:0] rd_bus_2;
	logic [`ID_DATA_W-1:0] sign_ext;

	assign sp_sel    = call | ret | push_pop;
	assign rf_we     = wb_we | pop;		// POP forces a write
	assign dest      = rd;
	assign imm16_out = imm16;
	assign pc_out    = pc_in;

	// Read port selection
	assign rd_idx_1 = sp_sel ? `ID_SP_REG : rs;
	assign rd_idx_2 = reg_2_sel ? rt : rd;	// rd doubles as store source

	// J-type or I-type immediate
	assign sign_ext = sign_ext_sel ? {{(`ID_DATA_W-26){imm26[25]}}, imm26}
	                               : {{(`ID_DATA_W-16){imm16[15]}}, imm16};

	reg_file u_reg_file (
		.clk       (clk),
		.rst       (rst),
		.we        (rf_we),
		.rd_idx_1  (rd_idx_1),
		.rd_idx_2  (rd_idx_2),
		.wr_idx    (wb_reg),
		.wr_data   (wb_data),
		.rd_data_1 (rd_bus_1),
		.rd_data_2 (rd_bus_2)
	);

	// ALU operand mux
	always_comb begin
		case (alu_src)
			SRC_REG_REG: begin
				alu_in_1 = rd_bus_1;
				alu_in_2 = rd_bus_2;
			end
			SRC_REG_IMM: begin
				alu_in_1 = branch ? pc_in : rd_bus_1;	// Branch target off PC
				alu_in_2 = sign_ext;
			end
			SRC_REG_SHIFT: begin
				alu_in_1 = rd_bus_1;
				// SP moves by one word
				alu_in_2 = sp_sel ? {{(`ID_DATA_W-1){1'b0}}, 1'b1}
				                  : {{(`ID_DATA_W-5){1'b0}}, shamt};
			end
			default: begin			// Sprite address computed downstream
				alu_in_1 = '0;
				alu_in_2 = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module id_ex_reg (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  in_valid,
	input  isa_pkg::opcode_t      opcode,
	input  logic [`ID_DATA_W-1:0] op1,
	input  logic [`ID_DATA_W-1:0] op2,
	input  logic [`ID_REG_W-1:0]  dest,
	input  logic [15:0]           imm16,
	input  logic [`ID_DATA_W-1:0] pc,
	output logic                  ex_valid,
	output isa_pkg::opcode_t      ex_opcode,
	output logic [`ID_DATA_W-1:0] ex_op1,
	output logic [`ID_DATA_W-1:0] ex_op2,
	output logic [`ID_REG_W-1:0]  ex_dest,
	output logic [15:0]           ex_imm16,
	output logic [`ID_DATA_W-1:0] ex_pc
);

	import isa_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid  <= 1'b0;
			ex_opcode <= OP_NOP;
			ex_op1    <= '0;
			ex_op2    <= '0;
			ex_dest   <= '0;
			ex_imm16  <= '0;
			ex_pc     <= '0;
		end else if (!stall) begin	// Stall holds everything
			ex_valid  <= in_valid;		// Low loads a bubble
			ex_opcode <= opcode;
			ex_op1    <= op1;
			ex_op2    <= op2;
			ex_dest   <= dest;
			ex_imm16  <= imm16;
			ex_pc     <= pc;
		end
	end

endmodule

`default_nettype wire

/* hdl/id_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module id_stage_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,	// Fetch side
	input  logic [`ID_DATA_W-1:0] instr,
	input  logic [`ID_DATA_W-1:0] pc,		// PC+1
	input  logic                  stall,
	input  logic                  wb_we,		// Write-back side
	input  logic [`ID_REG_W-1:0]  wb_reg,
	input  logic [`ID_DATA_W-1:0] wb_data,
	output logic                  ex_valid,
	output isa_pkg::opcode_t      ex_opcode,
	output logic [`ID_DATA_W-1:0] ex_op1,
	output logic [`ID_DATA_W-1:0] ex_op2,
	output logic [`ID_REG_W-1:0]  ex_dest,
	output logic [15:0]           ex_imm16,
	output logic [`ID_DATA_W-1:0] ex_pc
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	opcode_t               opcode;
	logic [`ID_REG_W-1:0]  rd, rs, rt;
	logic [4:0]            shamt;
	logic [15:0]           imm16;
	logic [25:0]           imm26;
	logic                  call, ret, branch, push_pop, pop, reg_2_sel, sign_ext_sel;
	alu_src_t              alu_src;
	logic [`ID_REG_W-1:0]  dest;
	logic [15:0]           imm16_out;
	logic [`ID_DATA_W-1:0] alu_in_1, alu_in_2, pc_out;

	// Field slices
	assign opcode = opcode_t'(instr[OPC_HI:OPC_LO]);
	assign rd     = instr[RD_HI:RD_LO];
	assign rs     = instr[RS_HI:RS_LO];
	assign rt     = instr[RT_HI:RT_LO];
	assign shamt  = instr[SHAMT_HI:SHAMT_LO];
	assign imm16  = instr[IMM16_HI:IMM16_LO];
	assign imm26  = instr[IMM26_HI:IMM26_LO];

	decode_control u_decode (
		.opcode (opcode), .call (call), .ret (ret), .branch (branch),
		.push_pop (push_pop), .pop (pop), .reg_2_sel (reg_2_sel),
		.sign_ext_sel (sign_ext_sel), .alu_src (alu_src)
	);

	id_unit u_id_unit (
		.clk (clk), .rst (rst), .call (call), .ret (ret), .branch (branch),
		.push_pop (push_pop), .pop (pop), .reg_2_sel (reg_2_sel),
		.sign_ext_sel (sign_ext_sel), .alu_src (alu_src),
		.wb_we (wb_we), .wb_reg (wb_reg), .wb_data (wb_data),
		.rd (rd), .rs (rs), .rt (rt), .shamt (shamt), .imm16 (imm16), .imm26 (imm26),
		.pc_in (pc), .dest (dest), .imm16_out (imm16_out),
		.alu_in_1 (alu_in_1), .alu_in_2 (alu_in_2), .pc_out (pc_out)
	);

	id_ex_reg u_id_ex_reg (
		.clk (clk), .rst (rst), .stall (stall), .in_valid (in_valid),
		.opcode (opcode), .op1 (alu_in_1), .op2 (alu_in_2), .dest (dest),
		.imm16 (imm16_out), .pc (pc_out),
		.ex_valid (ex_valid), .ex_opcode (ex_opcode), .ex_op1 (ex_op1),
		.ex_op2 (ex_op2), .ex_dest (ex_dest), .ex_imm16 (ex_imm16), .ex_pc (ex_pc)
	);

endmodule

`default_nettype wire

/* tb/id_stage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module id_stage_asserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  stall,
	input logic                  ex_valid,
	input logic [`ID_DATA_W-1:0] ex_op1,
	input logic [`ID_DATA_W-1:0] ex_op2,
	input logic [`ID_REG_W-1:0]  ex_dest,
	input isa_pkg::opcode_t      opcode,
	input logic [`ID_REG_W-1:0]  rd_idx_1	// Read port 1 index inside id_unit
);

	import isa_pkg::*;

	// No valid instruction leaves reset
	assert property (@(posedge clk) rst |=> !ex_valid)
		else $error("ex_valid high in the cycle after reset");

	// Stalled edge keeps the ID/EX contents
	assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(ex_valid) && $stable(ex_op1) && $stable(ex_op2) && $stable(ex_dest))
		else $error("ID/EX outputs changed under stall");

	// Stack ops read r29 on port 1
	assert property (@(posedge clk) disable iff (rst)
		opcode inside {OP_PUSH, OP_POP, OP_CALL, OP_RET} |-> rd_idx_1 == `ID_SP_REG)
		else $error("stack opcode did not select the stack pointer");

endmodule

bind id_stage_top id_stage_asserts u_asserts (
	.clk (clk), .rst (rst), .stall (stall), .ex_valid (ex_valid),
	.ex_op1 (ex_op1), .ex_op2 (ex_op2), .ex_dest (ex_dest),
	.opcode (opcode), .rd_idx_1 (u_id_unit.rd_idx_1)
);

`default_nettype wire

/* tb/id_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module id_stage_tb;

	import isa_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 10;
	localparam int MAX_VEC    = 64;
	localparam int SLACK      = 20;		// Spare cycles before the watchdog fires

	logic                  clk;
	logic                  rst;
	logic                  in_valid;
	logic [`ID_DATA_W-1:0] instr;
	logic [`ID_DATA_W-1:0] pc;
	logic                  stall;
	logic                  wb_we;
	logic [`ID_REG_W-1:0]  wb_reg;
	logic [`ID_DATA_W-1:0] wb_data;
	logic                  ex_valid;
	opcode_t               ex_opcode;
	logic [`ID_DATA_W-1:0] ex_op1;
	logic [`ID_DATA_W-1:0] ex_op2;
	logic [`ID_REG_W-1:0]  ex_dest;
	logic [15:0]           ex_imm16;
	logic [`ID_DATA_W-1:0] ex_pc;

	// One vector table entry per cycle
	logic [31:0] vec_in [MAX_VEC][7];	// stall in_valid wb_we wb_reg wb_data instr pc
	logic [31:0] vec_exp [MAX_VEC][4];	// ex_valid ex_op1 ex_op2 ex_dest
	int          num_vec;
	logic        loaded;

	// Pass-through fields of the last loaded instruction
	logic [5:0]            exp_opcode;
	logic [15:0]           exp_imm16;
	logic [`ID_DATA_W-1:0] exp_pc;

	id_stage_top dut (
		.clk (clk), .rst (rst), .in_valid (in_valid), .instr (instr), .pc (pc),
		.stall (stall), .wb_we (wb_we), .wb_reg (wb_reg), .wb_data (wb_data),
		.ex_valid (ex_valid), .ex_opcode (ex_opcode), .ex_op1 (ex_op1),
		.ex_op2 (ex_op2), .ex_dest (ex_dest), .ex_imm16 (ex_imm16), .ex_pc (ex_pc)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Budget is reset plus one cycle per vector and some slack
	initial begin
		wait (loaded);
		#((num_vec + RST_CYCLES + SLACK) * CLK_PERIOD);
		$display("Timeout: the run did not finish %0d vectors in time", num_vec);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] t [11];
		fd = $fopen("tb/id_stage_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file tb/id_stage_vectors.txt");
			$display("Some tests failed");
			$fatal(1, "missing vector file");
		end
		num_vec = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") continue;	// Blank or column notes
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", t[0], t[1], t[2],
			            t[3], t[4], t[5], t[6], t[7], t[8], t[9], t[10]);
			if (n != 11 || num_vec == MAX_VEC) begin
				$display("Bad or excess line %0d in the vector file", num_vec);
				$display("Some tests failed");
				$fatal(1, "vector file format");
			end
			for (int k = 0; k < 7; k++) vec_in[num_vec][k] = t[k];
			for (int k = 0; k < 4; k++) vec_exp[num_vec][k] = t[7 + k];
			num_vec++;
		end
		$fclose(fd);
	endtask

	task automatic apply_vector(input int i);
		stall    = vec_in[i][0][0];
		in_valid = vec_in[i][1][0];
		wb_we    = vec_in[i][2][0];
		wb_reg   = vec_in[i][3][`ID_REG_W-1:0];
		wb_data  = vec_in[i][4];
		instr    = vec_in[i][5];
		pc       = vec_in[i][6];
	endtask

	// Data fields are don't-care on a bubble
	task automatic check_vector(input int i);
		if (!vec_in[i][0][0]) begin		// Unstalled edge loads new fields
			exp_opcode = vec_in[i][5][31:26];
			exp_imm16  = vec_in[i][5][15:0];
			exp_pc     = vec_in[i][6];
		end
		check_value($sformatf("vector %0d ex_valid", i), 32'(ex_valid), vec_exp[i][0]);
		if (vec_exp[i][0][0]) begin
			check_value($sformatf("vector %0d ex_op1", i), ex_op1, vec_exp[i][1]);
			check_value($sformatf("vector %0d ex_op2", i), ex_op2, vec_exp[i][2]);
			check_value($sformatf("vector %0d ex_dest", i), 32'(ex_dest), vec_exp[i][3]);
			check_value($sformatf("vector %0d ex_opcode", i), 32'(ex_opcode),
			            32'(exp_opcode));
			check_value($sformatf("vector %0d ex_imm16", i), 32'(ex_imm16),
			            32'(exp_imm16));
			check_value($sformatf("vector %0d ex_pc", i), ex_pc, exp_pc);
		end
	endtask

	initial begin
		loaded     = 1'b0;
		rst        = 1'b1;
		in_valid   = 1'b0;
		instr      = '0;
		pc         = '0;
		stall      = 1'b0;
		wb_we      = 1'b0;
		wb_reg     = '0;
		wb_data    = '0;
		exp_opcode = '0;
		exp_imm16  = '0;
		exp_pc     = '0;
		load_vectors();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Everything cleared by reset
		check_value("ex_valid after reset", 32'(ex_valid), 32'd0);
		check_value("ex_opcode after reset", 32'(ex_opcode), 32'd0);
		check_value("ex_op1 after reset", ex_op1, 32'd0);
		check_value("ex_op2 after reset", ex_op2, 32'd0);
		check_value("ex_dest after reset", 32'(ex_dest), 32'd0);
		check_value("ex_imm16 after reset", 32'(ex_imm16), 32'd0);
		check_value("ex_pc after reset", ex_pc, 32'd0);

		for (int i = 0; i < num_vec; i++) begin
			apply_vector(i);
			@(negedge clk);		// One rising edge in between
			check_vector(i);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/id_stage_vectors.txt */
# stall in_valid wb_we wb_reg wb_data instr pc, then expected after the next edge:
# ex_valid ex_op1 ex_op2 ex_dest (hex; op and dest checked only when ex_valid is 1)
0 0 1 01 00000011 00000000 00000000 0 00000000 00000000 00
0 0 1 02 00000022 00000000 00000000 0 00000000 00000000 00
0 0 1 1d 00001000 00000000 00000000 0 00000000 00000000 00
0 1 1 01 00000099 04611000 00000101 1 00000011 00000022 03
0 1 0 00 00000000 04611000 00000102 1 00000099 00000022 03
0 1 0 00 00000000 18820005 00000103 1 00000022 00000005 04
0 1 0 00 00000000 1881fff0 00000104 1 00000099 fffffff0 04
0 1 0 00 00000000 30a08001 00000105 1 00000000 ffff8001 05
0 1 0 00 00000000 28220010 00000200 1 00000200 00000010 01
0 1 0 00 00000000 2ffffffc 00000300 1 00000300 fffffffc 1f
0 1 0 00 00000000 2c1f8000 00000304 1 00000304 001f8000 00
0 1 0 00 00000000 3c030000 00000305 1 00001000 00000001 00
0 1 0 00 00000000 44c00000 00000306 1 00001000 00000001 06
0 1 0 00 00000000 48000000 00000307 1 00001000 00000001 00
0 1 0 1d 00001001 40e00000 00000308 1 00001000 00000001 07
0 1 0 00 00000000 3c030000 00000309 1 00001001 00000001 00
0 1 0 00 00000000 350201c0 0000030a 1 00000022 00000007 08
1 1 0 00 00000000 1541e800 0000030b 1 00000022 00000007 08
1 1 0 00 00000000 1541e800 0000030b 1 00000022 00000007 08
0 1 0 00 00000000 1541e800 0000030b 1 00000099 00001001 0a
0 0 0 00 00000000 00000000 0000030c 0 00000000 00000000 00
1 0 0 00 00000000 00000000 0000030c 0 00000000 00000000 00
0 1 0 00 00000000 4d210000 0000030d 1 00000000 00000000 09
0 0 0 00 00000000 00000000 00000000 0 00000000 00000000 00

/* id_stage.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/decode_control.sv
hdl/reg_file.sv
hdl/id_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage_top.sv
tb/id_stage_asserts.sv
tb/id_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f id_stage.f --top-module id_stage_tb

output=$(./obj_dir/Vid_stage_tb | tee /dev/stderr)

if grep -q "All tests passed" <<< "$output"; then
	exit 0
fi
exit 1
